//--- verilog/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// the cluster needs at least 2 execute lanes
`define LANE_COUNT 4

`define DATA_WIDTH 32
`define IMM_WIDTH 16
`define SHAMT_WIDTH 5

// request identifier echoed back with each result
`define TAG_WIDTH 8

`endif

//--- verilog/alu_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

    // codes 29 and up are not listed and decode as a nop
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLTI, OP_SLTIU, OP_LUI,
        OP_CLO, OP_CLZ,
        OP_LW, OP_SW,
        OP_NOP
    } instrOp;

    typedef enum logic [2:0] {
        CALC_R,
        CALC_I,
        MEM_READ,
        MEM_WRITE,
        OTHER
    } instrClass;

    typedef enum logic [4:0] {
        ALU_ZERO, ALU_PASS_A, ALU_PASS_B,
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_CLO, ALU_CLZ
    } aluOp;

    typedef struct packed {
        instrOp                   opcode;
        logic [`DATA_WIDTH-1:0]   dataRs;
        logic [`DATA_WIDTH-1:0]   dataRt;
        logic [`IMM_WIDTH-1:0]    imm16;
        logic [`SHAMT_WIDTH-1:0]  shamt;
        logic [`TAG_WIDTH-1:0]    tag;
    } aluRequest;

    typedef struct packed {
        aluOp                     op;
        logic [`DATA_WIDTH-1:0]   operandA;  // shift amount for shifts
        logic [`DATA_WIDTH-1:0]   operandB;  // value being shifted for shifts
        logic [`TAG_WIDTH-1:0]    tag;
    } aluMicroOp;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]    tag;
        logic [`DATA_WIDTH-1:0]   value;
    } aluResult;

endpackage

`default_nettype wire

//--- verilog/instrDecoder.sv
`default_nettype none

`include "alu_macros.svh"

module instrDecoder (
    input  alu_pkg::aluRequest request,
    output alu_pkg::aluMicroOp microOp
);

    alu_pkg::instrClass     opClass;
    alu_pkg::aluOp          opAlu;
    logic                   zeroExtend;
    logic [`DATA_WIDTH-1:0] extImm;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;

    always_comb
    begin
        case (request.opcode)
            alu_pkg::OP_ADDI, alu_pkg::OP_ADDIU, alu_pkg::OP_ANDI, alu_pkg::OP_ORI,
            alu_pkg::OP_XORI, alu_pkg::OP_SLTI, alu_pkg::OP_SLTIU, alu_pkg::OP_LUI:
                opClass = alu_pkg::CALC_I;
            alu_pkg::OP_LW:  opClass = alu_pkg::MEM_READ;
            alu_pkg::OP_SW:  opClass = alu_pkg::MEM_WRITE;
            alu_pkg::OP_NOP: opClass = alu_pkg::OTHER;
            default:         opClass = (request.opcode > alu_pkg::OP_NOP) ?
                                       alu_pkg::OTHER : alu_pkg::CALC_R;
        endcase
    end

    always_comb
    begin
        case (request.opcode)
            alu_pkg::OP_ADD, alu_pkg::OP_ADDU, alu_pkg::OP_ADDI, alu_pkg::OP_ADDIU,
            alu_pkg::OP_LW, alu_pkg::OP_SW:            opAlu = alu_pkg::ALU_ADD;  // address sum
            alu_pkg::OP_SUB, alu_pkg::OP_SUBU:         opAlu = alu_pkg::ALU_SUB;
            alu_pkg::OP_AND, alu_pkg::OP_ANDI:         opAlu = alu_pkg::ALU_AND;
            alu_pkg::OP_OR, alu_pkg::OP_ORI:           opAlu = alu_pkg::ALU_OR;
            alu_pkg::OP_XOR, alu_pkg::OP_XORI:         opAlu = alu_pkg::ALU_XOR;
            alu_pkg::OP_NOR:                           opAlu = alu_pkg::ALU_NOR;
            alu_pkg::OP_SLT, alu_pkg::OP_SLTI:         opAlu = alu_pkg::ALU_SLT;
            alu_pkg::OP_SLTU, alu_pkg::OP_SLTIU:       opAlu = alu_pkg::ALU_SLTU;
            alu_pkg::OP_SLL, alu_pkg::OP_SLLV:         opAlu = alu_pkg::ALU_SLL;
            alu_pkg::OP_SRL, alu_pkg::OP_SRLV:         opAlu = alu_pkg::ALU_SRL;
            alu_pkg::OP_SRA, alu_pkg::OP_SRAV:         opAlu = alu_pkg::ALU_SRA;
            alu_pkg::OP_LUI:                           opAlu = alu_pkg::ALU_LUI;
            alu_pkg::OP_CLO:                           opAlu = alu_pkg::ALU_CLO;
            alu_pkg::OP_CLZ:                           opAlu = alu_pkg::ALU_CLZ;
            default:                                   opAlu = alu_pkg::ALU_ZERO;
        endcase
    end

    // the logical immediates take a zero-extended operand, everything else sign-extends
    assign zeroExtend = request.opcode inside {alu_pkg::OP_ANDI, alu_pkg::OP_ORI,
                                               alu_pkg::OP_XORI, alu_pkg::OP_LUI};

    assign extImm = zeroExtend ?
                    {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, request.imm16} :
                    {{(`DATA_WIDTH-`IMM_WIDTH){request.imm16[`IMM_WIDTH-1]}}, request.imm16};

    assign operandA = (request.opcode inside {alu_pkg::OP_SLL, alu_pkg::OP_SRL, alu_pkg::OP_SRA}) ?
                      {{(`DATA_WIDTH-`SHAMT_WIDTH){1'b0}}, request.shamt} : request.dataRs;

    always_comb
    begin
        case (opClass)
            alu_pkg::CALC_I, alu_pkg::MEM_READ, alu_pkg::MEM_WRITE: operandB = extImm;
            alu_pkg::CALC_R:                                        operandB = request.dataRt;
            default:                                                operandB = '0;
        endcase
    end

    assign microOp = '{op: opAlu, operandA: operandA, operandB: operandB, tag: request.tag};

endmodule

`default_nettype wire

//--- verilog/laneDispatcher.sv
`default_nettype none

`include "alu_macros.svh"

module laneDispatcher (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inValid,
    input  alu_pkg::aluRequest      inRequest,
    output logic                    inReady,
    output logic [`LANE_COUNT-1:0]  laneInValid,
    output alu_pkg::aluMicroOp      laneInOp,
    input  logic [`LANE_COUNT-1:0]  laneInReady
);

    localparam int ptrWidth = $clog2(`LANE_COUNT);

    logic [ptrWidth-1:0] writePtr;
    logic                accept;

    instrDecoder u_instrDecoder (
        .request (inRequest),
        .microOp (laneInOp)  // every lane sees the decoded op, only one gets valid
    );

    assign inReady = laneInReady[writePtr];
    assign accept  = inValid && inReady;

    always_comb
    begin
        laneInValid           = '0;
        laneInValid[writePtr] = inValid;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            writePtr <= '0;
        else if (accept)
            writePtr <= (writePtr == ptrWidth'(`LANE_COUNT-1)) ? '0 : writePtr + 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/execLane.sv
`default_nettype none

`include "alu_macros.svh"

module execLane (
    input  logic               clk,
    input  logic               reset,
    input  logic               inValid,
    input  alu_pkg::aluMicroOp inOp,
    output logic               inReady,
    output logic               outValid,
    output alu_pkg::aluResult  outResult,
    input  logic               outReady
);

    logic                   full;
    logic                   accept;
    logic [`DATA_WIDTH-1:0] aluValue;
    logic [`SHAMT_WIDTH-1:0] shiftAmount;
    alu_pkg::aluResult      resultReg;

    function automatic logic [`DATA_WIDTH-1:0] countLeading(
        input logic [`DATA_WIDTH-1:0] value,
        input logic                   bitValue
    );
        logic [`DATA_WIDTH-1:0] count;
        logic                   stop;
        count = '0;
        stop  = 1'b0;
        for (int i = `DATA_WIDTH-1; i >= 0; i--)
        begin
            if (!stop && value[i] == bitValue)
                count = count + 1'b1;
            else
                stop = 1'b1;
        end
        return count;
    endfunction

    assign shiftAmount = inOp.operandA[`SHAMT_WIDTH-1:0];

    always_comb
    begin
        case (inOp.op)
            alu_pkg::ALU_PASS_A: aluValue = inOp.operandA;
            alu_pkg::ALU_PASS_B: aluValue = inOp.operandB;
            alu_pkg::ALU_ADD:    aluValue = inOp.operandA + inOp.operandB;
            alu_pkg::ALU_SUB:    aluValue = inOp.operandA - inOp.operandB;
            alu_pkg::ALU_AND:    aluValue = inOp.operandA & inOp.operandB;
            alu_pkg::ALU_OR:     aluValue = inOp.operandA | inOp.operandB;
            alu_pkg::ALU_XOR:    aluValue = inOp.operandA ^ inOp.operandB;
            alu_pkg::ALU_NOR:    aluValue = ~(inOp.operandA | inOp.operandB);
            alu_pkg::ALU_SLT:    aluValue = `DATA_WIDTH'($signed(inOp.operandA) <
                                                         $signed(inOp.operandB));
            alu_pkg::ALU_SLTU:   aluValue = `DATA_WIDTH'(inOp.operandA < inOp.operandB);
            alu_pkg::ALU_SLL:    aluValue = inOp.operandB << shiftAmount;
            alu_pkg::ALU_SRL:    aluValue = inOp.operandB >> shiftAmount;
            alu_pkg::ALU_SRA:    aluValue = $signed(inOp.operandB) >>> shiftAmount;
            alu_pkg::ALU_LUI:    aluValue = {inOp.operandB[`IMM_WIDTH-1:0],
                                             {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
            alu_pkg::ALU_CLO:    aluValue = countLeading(inOp.operandA, 1'b1);
            alu_pkg::ALU_CLZ:    aluValue = countLeading(inOp.operandA, 1'b0);
            default:             aluValue = '0;
        endcase
    end

    assign inReady   = !full || outReady;  // a draining result frees the slot this cycle
    assign accept    = inValid && inReady;
    assign outValid  = full;
    assign outResult = resultReg;

    always_ff @(posedge clk)
    begin
        if (reset)
            full <= 1'b0;
        else if (accept)
            full <= 1'b1;
        else if (outReady)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            resultReg <= '{tag: inOp.tag, value: aluValue};
    end

endmodule

`default_nettype wire

//--- verilog/resultCollector.sv
`default_nettype none

`include "alu_macros.svh"

module resultCollector (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`LANE_COUNT-1:0]  laneOutValid,
    input  alu_pkg::aluResult       laneOutResult [`LANE_COUNT],
    output logic [`LANE_COUNT-1:0]  laneOutReady,
    output logic                    outValid,
    output alu_pkg::aluResult       outResult,
    input  logic                    outReady
);

    localparam int ptrWidth = $clog2(`LANE_COUNT);

    logic [ptrWidth-1:0] readPtr;
    logic                drain;

    // lanes are read in the order the dispatcher filled them
    assign outValid  = laneOutValid[readPtr];
    assign outResult = laneOutResult[readPtr];
    assign drain     = outValid && outReady;

    always_comb
    begin
        laneOutReady          = '0;
        laneOutReady[readPtr] = outReady;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            readPtr <= '0;
        else if (drain)
            readPtr <= (readPtr == ptrWidth'(`LANE_COUNT-1)) ? '0 : readPtr + 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/aluCluster.sv
`default_nettype none

`include "alu_macros.svh"

module aluCluster (
    input  logic               clk,
    input  logic               reset,
    input  logic               inValid,
    input  alu_pkg::aluRequest inRequest,
    output logic               inReady,
    output logic               outValid,
    output alu_pkg::aluResult  outResult,
    input  logic               outReady
);

    logic [`LANE_COUNT-1:0] laneInValid;
    logic [`LANE_COUNT-1:0] laneInReady;
    alu_pkg::aluMicroOp     laneInOp;
    logic [`LANE_COUNT-1:0] laneOutValid;
    logic [`LANE_COUNT-1:0] laneOutReady;
    alu_pkg::aluResult      laneOutResult [`LANE_COUNT];

    laneDispatcher u_laneDispatcher (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .inRequest   (inRequest),
        .inReady     (inReady),
        .laneInValid (laneInValid),
        .laneInOp    (laneInOp),
        .laneInReady (laneInReady)
    );

    for (genvar i = 0; i < `LANE_COUNT; i++)
    begin : gLane
        execLane u_execLane (
            .clk       (clk),
            .reset     (reset),
            .inValid   (laneInValid[i]),
            .inOp      (laneInOp),
            .inReady   (laneInReady[i]),
            .outValid  (laneOutValid[i]),
            .outResult (laneOutResult[i]),
            .outReady  (laneOutReady[i])
        );
    end

    resultCollector u_resultCollector (
        .clk           (clk),
        .reset         (reset),
        .laneOutValid  (laneOutValid),
        .laneOutResult (laneOutResult),
        .laneOutReady  (laneOutReady),
        .outValid      (outValid),
        .outResult     (outResult),
        .outReady      (outReady)
    );

endmodule

`default_nettype wire

//--- test/aluCluster_assert.sv
`default_nettype none

module aluCluster_assert (
    input logic              clk,
    input logic              reset,
    input logic              inValid,
    input logic              inReady,
    input logic              outValid,
    input alu_pkg::aluResult outResult,
    input logic              outReady
);
    timeunit 1ns;
    timeprecision 1ps;

    int   assertFailures = 0;
    logic firstAccepted;

    always_ff @(posedge clk)
    begin
        if (reset)
            firstAccepted <= 1'b0;
        else if (inValid && inReady)
            firstAccepted <= 1'b1;
    end

    stallStable: assert property (@(posedge clk) disable iff (reset)
                                  outValid && !outReady |=> $stable(outResult))
    else
    begin
        assertFailures++;
        $error("outResult changed while outValid was high and outReady low");
    end

    resetEmpty: assert property (@(posedge clk) reset |=> !outValid)
    else
    begin
        assertFailures++;
        $error("outValid was high in the cycle after reset");
    end

    // an empty cluster has a free lane under the write pointer
    readyAfterReset: assert property (@(posedge clk) disable iff (reset) !firstAccepted |-> inReady)
    else
    begin
        assertFailures++;
        $error("inReady fell before the first request was accepted");
    end

endmodule

`default_nettype wire

//--- test/aluCluster_tb.sv
`default_nettype none

`include "alu_macros.svh"

module aluCluster_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int requestTotal = 1 + 48 + 48 + 48 + 400;
    localparam int cycleLimit   = 20 * requestTotal + 100;

    logic                  clk, reset, inValid, inReady, outValid, outReady;
    alu_pkg::aluRequest    inRequest;
    alu_pkg::aluResult     outResult;
    alu_pkg::aluResult     expectQueue[$];
    int                    acceptEdges[$];
    logic [31:0]           lcgState = 32'ha1c1_69d5;
    logic [`TAG_WIDTH-1:0] nextTag = '0;
    int                    edgeCount = 0, cycleCount = 0, passCount = 0, failCount = 0;
    int                    testPass, testFail;
    bit                    measureLatency = 1'b0;
    string                 currentTest;

    aluCluster u_aluCluster (.*);

    bind aluCluster aluCluster_assert u_aluCluster_assert (.*);

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};  // low state bits have short periods
    endfunction

    function automatic logic [31:0] pickOperand();
        logic [31:0] r;
        r = nextRandom();
        case (r % 6)
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            default: return nextRandom();
        endcase
    endfunction

    function automatic alu_pkg::aluRequest makeRequest(alu_pkg::instrOp op, logic [31:0] rs,
                                                       logic [31:0] rt, logic [15:0] imm);
        nextTag++;
        return '{opcode: op, dataRs: rs, dataRt: rt, imm16: imm, shamt: 5'(nextRandom()),
                 tag: nextTag};
    endfunction

    function automatic logic [31:0] leadingRun(logic [31:0] value, logic bitValue);
        int n;
        n = 0;
        while (n < 32 && value[31-n] == bitValue)
            n++;
        return n;
    endfunction

    function automatic logic [31:0] expectedResult(alu_pkg::aluRequest req);
        logic [31:0] rs, rt, sImm, zImm;
        rs   = req.dataRs;
        rt   = req.dataRt;
        sImm = {{16{req.imm16[15]}}, req.imm16};
        zImm = {16'h0000, req.imm16};
        case (req.opcode)
            alu_pkg::OP_ADD, alu_pkg::OP_ADDU:   return rs + rt;
            alu_pkg::OP_SUB, alu_pkg::OP_SUBU:   return rs - rt;
            alu_pkg::OP_AND:                     return rs & rt;
            alu_pkg::OP_OR:                      return rs | rt;
            alu_pkg::OP_XOR:                     return rs ^ rt;
            alu_pkg::OP_NOR:                     return ~(rs | rt);
            alu_pkg::OP_SLT:                     return {31'b0, $signed(rs) < $signed(rt)};
            alu_pkg::OP_SLTU:                    return {31'b0, rs < rt};
            alu_pkg::OP_SLL:                     return rt << req.shamt;
            alu_pkg::OP_SRL:                     return rt >> req.shamt;
            alu_pkg::OP_SRA:                     return $signed(rt) >>> req.shamt;
            alu_pkg::OP_SLLV:                    return rt << rs[4:0];
            alu_pkg::OP_SRLV:                    return rt >> rs[4:0];
            alu_pkg::OP_SRAV:                    return $signed(rt) >>> rs[4:0];
            alu_pkg::OP_ADDI, alu_pkg::OP_ADDIU,
            alu_pkg::OP_LW, alu_pkg::OP_SW:      return rs + sImm;  // load or store address
            alu_pkg::OP_ANDI:                    return rs & zImm;
            alu_pkg::OP_ORI:                     return rs | zImm;
            alu_pkg::OP_XORI:                    return rs ^ zImm;
            alu_pkg::OP_SLTI:                    return {31'b0, $signed(rs) < $signed(sImm)};
            alu_pkg::OP_SLTIU:                   return {31'b0, rs < sImm};
            alu_pkg::OP_LUI:                     return {req.imm16, 16'h0000};
            alu_pkg::OP_CLO:                     return leadingRun(rs, 1'b1);
            alu_pkg::OP_CLZ:                     return leadingRun(rs, 1'b0);
            default:                             return '0;  // nop and unlisted codes
        endcase
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected === actual)
            passCount++;
        else
        begin
            failCount++;
            $display("ERROR test %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic sendRequest(alu_pkg::aluRequest req, bit randomReady);
        inValid   <= 1'b1;
        inRequest <= req;
        do
        begin
            if (randomReady)
                outReady <= (nextRandom() % 2) == 1;
            @(posedge clk);
        end
        while (!inReady);
        inValid <= 1'b0;
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testPass    = passCount;
        testFail    = failCount;
    endtask

    task automatic finishTest();
        do
            @(negedge clk);
        while (expectQueue.size() != 0);
        @(posedge clk);
        $display("test %s done: passed %0d, failed %0d", currentTest,
                 passCount - testPass, failCount - testFail);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the cluster stopped producing results after %0d cycles", cycleCount);
        $display("Simulation FAILED");
        $finish;
    end

    // the scoreboard samples each transfer on the edge where it happens
    always @(posedge clk)
    begin
        edgeCount++;
        if (!reset)
        begin
            if (!inReady)
                checkValue({currentTest, " stall depth"}, `LANE_COUNT, expectQueue.size());
            if (outValid && outReady)
            begin
                if (expectQueue.size() == 0)
                begin
                    failCount++;
                    $display("test %s: result with tag %h arrived with no request outstanding",
                             currentTest, outResult.tag);
                end
                else
                begin
                    if (measureLatency)
                        checkValue({currentTest, " latency"}, 1, edgeCount - acceptEdges[0]);
                    checkValue({currentTest, " tag"}, expectQueue[0].tag, outResult.tag);
                    checkValue({currentTest, " value"}, expectQueue[0].value, outResult.value);
                    void'(expectQueue.pop_front());
                    void'(acceptEdges.pop_front());
                end
            end
            if (inValid && inReady)
            begin
                expectQueue.push_back(alu_pkg::aluResult'{tag: inRequest.tag,
                                                          value: expectedResult(inRequest)});
                acceptEdges.push_back(edgeCount);
            end
        end
    end

    initial
    begin
        logic [31:0] pick;
        logic [31:0] value;
        reset     = 1'b1;
        inValid   = 1'b0;
        inRequest = '0;
        outReady  = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        startTest("reset");
        checkValue("reset outValid", 0, outValid);
        checkValue("reset inReady", 1, inReady);
        outReady       <= 1'b1;
        measureLatency = 1'b1;
        sendRequest(makeRequest(alu_pkg::OP_ADD, pickOperand(), pickOperand(), 16'h0), 1'b0);
        finishTest();
        measureLatency = 1'b0;

        startTest("rtype");
        repeat (48)
            sendRequest(makeRequest(alu_pkg::instrOp'(5'(nextRandom() % 10)), pickOperand(),
                                    pickOperand(), 16'(nextRandom())), 1'b0);
        finishTest();

        startTest("immediate");
        repeat (48)
        begin
            pick = nextRandom() % 10;  // ADDI through LUI, then LW and SW
            sendRequest(makeRequest(alu_pkg::instrOp'(5'(pick < 8 ? pick + 16 : pick + 18)),
                                    pickOperand(), pickOperand(),
                                    16'(nextRandom()) | 16'h8000), 1'b0);
        end
        finishTest();

        startTest("shift_count");
        repeat (36)
            sendRequest(makeRequest(alu_pkg::instrOp'(5'(10 + nextRandom() % 6)), nextRandom(),
                                    pickOperand(), 16'(nextRandom())), 1'b0);
        for (int i = 0; i < 4; i++)
        begin
            value = (i == 0) ? 32'h0 : (i == 1) ? 32'hffff_ffff :
                    nextRandom() >> (nextRandom() % 32);
            sendRequest(makeRequest(alu_pkg::OP_CLO, ~value, pickOperand(), 16'h0), 1'b0);
            sendRequest(makeRequest(alu_pkg::OP_CLZ, value, pickOperand(), 16'h0), 1'b0);
            sendRequest(makeRequest(alu_pkg::OP_NOP, value, pickOperand(),
                                    16'(nextRandom())), 1'b0);
        end
        finishTest();

        startTest("backpressure");
        repeat (400)
            sendRequest(makeRequest(alu_pkg::instrOp'(5'(nextRandom())), pickOperand(),
                                    pickOperand(), 16'(nextRandom())), 1'b1);
        outReady <= 1'b1;
        finishTest();

        failCount += u_aluCluster.u_aluCluster_assert.assertFailures;
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/instrDecoder.sv
verilog/laneDispatcher.sv
verilog/execLane.sv
verilog/resultCollector.sv
verilog/aluCluster.sv
test/aluCluster_assert.sv
test/aluCluster_tb.sv
